//--- bicubic.sv
`timescale 1ns/1ns

module bicubic import bicubic_pkg::*; (
    input  logic      CLK,
    input  logic      RST,
    input  coord_t    v0_i,
    input  coord_t    h0_i,
    input  src_size_t sw_i,
    input  src_size_t sh_i,
    input  tgt_size_t tw_i,
    input  tgt_size_t th_i,
    output logic      rom_en_o,
    output rom_addr_t rom_addr_o,
    input  pixel_t    rom_data_i,
    output logic      mem_we_o,
    output mem_addr_t mem_addr_o,
    output pixel_t    mem_data_o,
    output logic      done_o
);

    div_if div_bus ();
    tap_if horz_bus ();
    tap_if vert_bus ();

    logic   tab_wr, tab_wr_row;
    coord_t tab_wr_idx, tab_wr_int, tab_rd_col, tab_rd_row;
    frac_t  tab_wr_frac;
    coord_t col_int, row_int, row_sel;
    frac_t  col_frac, row_frac;
    logic   fetch, eng_sel, res_valid;
    pixel_t res;

    scan_ctrl u_scan_ctrl (
        .CLK(CLK), .RST(RST),
        .sw_i(sw_i), .sh_i(sh_i), .tw_i(tw_i), .th_i(th_i),
        .div(div_bus.master),
        .tab_wr_o(tab_wr), .tab_wr_row_o(tab_wr_row), .tab_wr_idx_o(tab_wr_idx),
        .tab_wr_int_o(tab_wr_int), .tab_wr_frac_o(tab_wr_frac),
        .tab_rd_col_o(tab_rd_col), .tab_rd_row_o(tab_rd_row),
        .row_int_i(row_int), .row_frac_i(row_frac),
        .row_sel_o(row_sel), .fetch_o(fetch),
        .res_valid_i(res_valid), .res_i(res),
        .vert_tap(vert_bus.src), .eng_sel_o(eng_sel),
        .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o), .mem_data_o(mem_data_o),
        .done_o(done_o)
    );

    phase_divider u_phase_divider (.CLK(CLK), .RST(RST), .div(div_bus.slave));

    phase_table u_phase_table (
        .CLK(CLK), .RST(RST),
        .wr_i(tab_wr), .wr_row_i(tab_wr_row), .wr_idx_i(tab_wr_idx),
        .wr_int_i(tab_wr_int), .wr_frac_i(tab_wr_frac),
        .rd_col_i(tab_rd_col), .rd_row_i(tab_rd_row),
        .col_int_o(col_int), .col_frac_o(col_frac),
        .row_int_o(row_int), .row_frac_o(row_frac)
    );

    tap_fetch u_tap_fetch (
        .CLK(CLK), .RST(RST), .v0_i(v0_i), .h0_i(h0_i),
        .fetch_i(fetch), .row_sel_i(row_sel),
        .col_int_i(col_int), .col_frac_i(col_frac),
        .rom_en_o(rom_en_o), .rom_addr_o(rom_addr_o), .rom_data_i(rom_data_i),
        .horz_tap(horz_bus.src)
    );

    cubic_engine u_cubic_engine (
        .CLK(CLK), .RST(RST), .eng_sel_i(eng_sel),
        .horz_tap(horz_bus.sink), .vert_tap(vert_bus.sink),
        .res_valid_o(res_valid), .res_o(res)
    );

endmodule

//--- bicubic_assert.sv
`timescale 1ns/1ns

module bicubic_assert (
    input logic CLK,
    input logic RST,
    input logic rom_en_o,
    input logic mem_we_o,
    input logic done_o
);

    // done is a held state until the next reset
    done_held: assert property (@(posedge CLK) disable iff (RST) $past(done_o) |-> done_o)
        else $error("done_o fell without RST");

    no_write_after_done: assert property (@(posedge CLK) done_o |-> !mem_we_o)
        else $error("mem_we_o pulsed while done_o high");

    // outputs quiet once a reset edge has passed
    quiet_in_reset: assert property (@(posedge CLK) $past(RST) |-> !rom_en_o && !mem_we_o)
        else $error("rom_en_o or mem_we_o high during RST");

endmodule

//--- bicubic_ifs.sv
`timescale 1ns/1ns

// phase divider request and answer
interface div_if import bicubic_pkg::*; ();
    logic   start;
    coord_t dividend;
    coord_t divisor;
    logic   done;
    frac_t  frac;

    modport master (output start, dividend, divisor, input done, frac);
    modport slave  (input start, dividend, divisor, output done, frac);
endinterface

// four taps and a phase for one cubic pass
interface tap_if import bicubic_pkg::*; ();
    pixel_t p0;
    pixel_t p1;
    pixel_t p2;
    pixel_t p3;
    frac_t  frac;
    logic   valid;

    modport src  (output p0, p1, p2, p3, frac, valid);
    modport sink (input p0, p1, p2, p3, frac, valid);
endinterface

//--- bicubic_pkg.sv
package bicubic_pkg;

    localparam int IMG_DIM     = 100;  // rom row length
    localparam int FRAC_BITS   = 8;
    localparam int DIV_STEPS   = 8;
    localparam int ENG_LATENCY = 3;
    localparam int TABLE_DEPTH = 64;   // entries per axis

    // origins, target coordinates, integer positions
    typedef logic [6:0] coord_t;

    typedef logic [4:0] src_size_t;    // sw, sh
    typedef logic [5:0] tgt_size_t;    // tw, th

    typedef logic [FRAC_BITS-1:0] frac_t;  // q0.8
    typedef logic [7:0] pixel_t;

    typedef logic [13:0] rom_addr_t;
    typedef logic [13:0] mem_addr_t;   // {row, col}

    typedef enum logic [1:0] {
        PH_INIT,
        PH_RUN,
        PH_DONE
    } phase_t;

    typedef enum logic [2:0] {
        RS_FETCH,
        RS_HWAIT,
        RS_VPASS,
        RS_VWAIT,
        RS_WRITE
    } run_state_t;

endpackage

//--- cubic_engine.sv
`timescale 1ns/1ns

module cubic_engine import bicubic_pkg::*; (
    input  logic   CLK,
    input  logic   RST,
    input  logic   eng_sel_i,   // 1 takes the vertical pass
    tap_if.sink    horz_tap,
    tap_if.sink    vert_tap,
    output logic   res_valid_o,
    output pixel_t res_o
);

    logic [ENG_LATENCY-1:0] vld_q;
    frac_t              x_s1, x_s2, x2_s2, x3_s2;
    pixel_t             p0_s1, p1_s1, p2_s1, p3_s1, p1_s2;
    logic signed [11:0] ca_s2, cb_s2, cc_s2;
    logic [15:0]        xx_r, xxx_r;
    logic signed [11:0] s0, s1, s2, s3;
    logic signed [21:0] acc;
    logic signed [12:0] acc_sh;
    pixel_t             res_q;

    always_ff @(posedge CLK) begin
        if (RST) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[ENG_LATENCY-2:0], eng_sel_i ? vert_tap.valid : horz_tap.valid};
        end
    end

    // stage 1 input mux
    always_ff @(posedge CLK) begin
        x_s1  <= eng_sel_i ? vert_tap.frac : horz_tap.frac;
        p0_s1 <= eng_sel_i ? vert_tap.p0 : horz_tap.p0;
        p1_s1 <= eng_sel_i ? vert_tap.p1 : horz_tap.p1;
        p2_s1 <= eng_sel_i ? vert_tap.p2 : horz_tap.p2;
        p3_s1 <= eng_sel_i ? vert_tap.p3 : horz_tap.p3;
    end

    // stage 2 powers of x and tap combinations
    always_comb begin
        xx_r  = x_s1 * x_s1 + 16'd128;
        xxx_r = xx_r[15:8] * x_s1 + 16'd128;
        s0    = $signed({4'b0000, p0_s1});
        s1    = $signed({4'b0000, p1_s1});
        s2    = $signed({4'b0000, p2_s1});
        s3    = $signed({4'b0000, p3_s1});
    end

    always_ff @(posedge CLK) begin
        x_s2  <= x_s1;
        x2_s2 <= xx_r[15:8];
        x3_s2 <= xxx_r[15:8];
        p1_s2 <= p1_s1;
        ca_s2 <= s2 - s0;
        cb_s2 <= 2 * s0 - 5 * s1 + 4 * s2 - s3;
        cc_s2 <= 3 * s1 - 3 * s2 + s3 - s0;
    end

    // stage 3 weighted sum, round, clamp
    always_comb begin
        acc = $signed({5'b00000, p1_s2, 9'b0_0000_0000})
            + $signed({1'b0, x_s2}) * ca_s2
            + $signed({1'b0, x2_s2}) * cb_s2
            + $signed({1'b0, x3_s2}) * cc_s2
            + 22'sd256;
        acc_sh = acc[21:9];
    end

    always_ff @(posedge CLK) begin
        if (acc_sh < 0) begin
            res_q <= 8'd0;
        end else if (acc_sh > 255) begin
            res_q <= 8'd255;
        end else begin
            res_q <= acc_sh[7:0];
        end
    end

    assign res_valid_o = vld_q[ENG_LATENCY-1];
    assign res_o       = res_q;

endmodule

//--- phase_divider.sv
`timescale 1ns/1ns

module phase_divider import bicubic_pkg::*; (
    input  logic CLK,
    input  logic RST,
    div_if.slave div
);

    logic                         busy_q;
    logic                         done_q;
    logic [$clog2(DIV_STEPS)-1:0] step_q;
    coord_t                       rem_q;
    coord_t                       dsor_q;
    frac_t                        quo_q;

    logic                         load;
    coord_t                       rem_src;
    coord_t                       dsor_src;
    logic [7:0]                   shifted;
    logic [8:0]                   diff;
    logic                         q_bit;
    coord_t                       rem_nxt;

    assign load = div.start && !busy_q;

    // first step runs in the start cycle straight off the request
    always_comb begin
        rem_src  = busy_q ? rem_q : div.dividend;
        dsor_src = busy_q ? dsor_q : div.divisor;
        shifted  = {rem_src, 1'b0};
        diff     = {1'b0, shifted} - {2'b00, dsor_src};
        q_bit    = !diff[8];                       // no borrow
        rem_nxt  = q_bit ? diff[6:0] : shifted[6:0];
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            step_q <= '0;
        end else begin
            done_q <= 1'b0;
            if (load) begin
                busy_q <= 1'b1;
                step_q <= 1;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == DIV_STEPS - 1) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;                // last quotient bit lands here
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (load || busy_q) begin
            rem_q  <= rem_nxt;
            dsor_q <= dsor_src;
            quo_q  <= {quo_q[FRAC_BITS-2:0], q_bit};
        end
    end

    assign div.done = done_q;
    assign div.frac = quo_q;

endmodule

//--- phase_table.sv
`timescale 1ns/1ns

module phase_table import bicubic_pkg::*; (
    input  logic   CLK,
    input  logic   RST,
    input  logic   wr_i,
    input  logic   wr_row_i,     // 1 selects the row table
    input  coord_t wr_idx_i,
    input  coord_t wr_int_i,
    input  frac_t  wr_frac_i,
    input  coord_t rd_col_i,
    input  coord_t rd_row_i,
    output coord_t col_int_o,
    output frac_t  col_frac_o,
    output coord_t row_int_o,
    output frac_t  row_frac_o
);

    // entry is {integer offset from window origin, phase}
    logic [$bits(coord_t)+$bits(frac_t)-1:0] col_tab [TABLE_DEPTH];
    logic [$bits(coord_t)+$bits(frac_t)-1:0] row_tab [TABLE_DEPTH];

    logic [$clog2(TABLE_DEPTH)-1:0] wr_a;
    logic [$clog2(TABLE_DEPTH)-1:0] col_a;
    logic [$clog2(TABLE_DEPTH)-1:0] row_a;

    assign wr_a  = wr_idx_i[$clog2(TABLE_DEPTH)-1:0];
    assign col_a = rd_col_i[$clog2(TABLE_DEPTH)-1:0];
    assign row_a = rd_row_i[$clog2(TABLE_DEPTH)-1:0];

    always_ff @(posedge CLK) begin
        if (wr_i && !RST) begin
            if (wr_row_i) begin
                row_tab[wr_a] <= {wr_int_i, wr_frac_i};
            end else begin
                col_tab[wr_a] <= {wr_int_i, wr_frac_i};
            end
        end
    end

    assign {col_int_o, col_frac_o} = col_tab[col_a];
    assign {row_int_o, row_frac_o} = row_tab[row_a];

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the bicubic scaler testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_bicubic -f tb.f -o sim_bicubic
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_bicubic
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

//--- scan_ctrl.sv
`timescale 1ns/1ns

module scan_ctrl import bicubic_pkg::*; (
    input  logic      CLK,
    input  logic      RST,
    input  src_size_t sw_i,
    input  src_size_t sh_i,
    input  tgt_size_t tw_i,
    input  tgt_size_t th_i,
    div_if.master     div,
    output logic      tab_wr_o,
    output logic      tab_wr_row_o,
    output coord_t    tab_wr_idx_o,
    output coord_t    tab_wr_int_o,
    output frac_t     tab_wr_frac_o,
    output coord_t    tab_rd_col_o,
    output coord_t    tab_rd_row_o,
    input  coord_t    row_int_i,
    input  frac_t     row_frac_i,
    output coord_t    row_sel_o,
    output logic      fetch_o,
    input  logic      res_valid_i,
    input  pixel_t    res_i,
    tap_if.src        vert_tap,
    output logic      eng_sel_o,
    output logic      mem_we_o,
    output mem_addr_t mem_addr_o,
    output pixel_t    mem_data_o,
    output logic      done_o
);

    phase_t     phase_q;
    run_state_t rs_q;
    logic       row_axis_q;    // columns first, then rows
    logic       div_busy_q;
    logic       adv_q;
    coord_t     idx_q;
    coord_t     acc_int_q;
    coord_t     acc_rem_q;
    coord_t     tx_q;
    coord_t     ty_q;
    logic [1:0] pass_q;
    logic       we_q;
    pixel_t     data_q;
    pixel_t     hres_q [4];    // horizontal results, top row first

    coord_t     tw_m1;
    coord_t     th_m1;
    coord_t     tgt_m1;
    coord_t     src_m1;
    coord_t     rem_sum;

    assign tw_m1   = {1'b0, tw_i} - 7'd1;
    assign th_m1   = {1'b0, th_i} - 7'd1;
    assign tgt_m1  = row_axis_q ? th_m1 : tw_m1;
    assign src_m1  = row_axis_q ? {2'b00, sh_i} - 7'd1 : {2'b00, sw_i} - 7'd1;
    assign rem_sum = acc_rem_q + src_m1;

    assign div.start    = (phase_q == PH_INIT) && !div_busy_q && !adv_q;
    assign div.dividend = acc_rem_q;
    assign div.divisor  = tgt_m1;

    assign tab_wr_o      = (phase_q == PH_INIT) && div.done;
    assign tab_wr_row_o  = row_axis_q;
    assign tab_wr_idx_o  = idx_q;
    assign tab_wr_int_o  = acc_int_q;
    assign tab_wr_frac_o = div.frac;
    assign tab_rd_col_o  = tx_q;
    assign tab_rd_row_o  = ty_q;

    assign row_sel_o = row_int_i + {5'b00000, pass_q} - 7'd1;  // int-1 .. int+2
    assign fetch_o   = (phase_q == PH_RUN) && (rs_q == RS_FETCH);
    assign eng_sel_o = (phase_q == PH_RUN) && (rs_q == RS_VPASS);

    assign vert_tap.p0    = hres_q[0];
    assign vert_tap.p1    = hres_q[1];
    assign vert_tap.p2    = hres_q[2];
    assign vert_tap.p3    = hres_q[3];
    assign vert_tap.frac  = row_frac_i;
    assign vert_tap.valid = eng_sel_o;

    assign mem_we_o   = we_q;
    assign mem_addr_o = {ty_q, tx_q};
    assign mem_data_o = data_q;
    assign done_o     = (phase_q == PH_DONE);

    always_ff @(posedge CLK) begin
        if (RST) begin
            phase_q    <= PH_INIT;
            rs_q       <= RS_FETCH;
            row_axis_q <= 1'b0;
            div_busy_q <= 1'b0;
            adv_q      <= 1'b0;
            idx_q      <= '0;
            acc_int_q  <= '0;
            acc_rem_q  <= '0;
            tx_q       <= '0;
            ty_q       <= '0;
            pass_q     <= '0;
            we_q       <= 1'b0;
        end else begin
            case (phase_q)
                PH_INIT: begin
                    if (div.start) begin
                        div_busy_q <= 1'b1;
                    end
                    if (div.done) begin
                        div_busy_q <= 1'b0;
                        adv_q      <= 1'b1;
                    end
                    if (adv_q) begin
                        adv_q <= 1'b0;
                        if (idx_q == tgt_m1) begin
                            idx_q      <= '0;
                            acc_int_q  <= '0;
                            acc_rem_q  <= '0;
                            row_axis_q <= 1'b1;
                            if (row_axis_q) begin
                                phase_q <= PH_RUN;
                            end
                        end else begin
                            idx_q <= idx_q + 7'd1;
                            if (rem_sum >= tgt_m1) begin  // carry into integer part
                                acc_rem_q <= rem_sum - tgt_m1;
                                acc_int_q <= acc_int_q + 7'd1;
                            end else begin
                                acc_rem_q <= rem_sum;
                            end
                        end
                    end
                end
                PH_RUN: begin
                    case (rs_q)
                        RS_FETCH: rs_q <= RS_HWAIT;
                        RS_HWAIT: begin
                            if (res_valid_i) begin
                                pass_q <= pass_q + 2'd1;
                                rs_q   <= (pass_q == 2'd3) ? RS_VPASS : RS_FETCH;
                            end
                        end
                        RS_VPASS: rs_q <= RS_VWAIT;
                        RS_VWAIT: begin
                            if (res_valid_i) begin
                                we_q <= 1'b1;
                                rs_q <= RS_WRITE;
                            end
                        end
                        RS_WRITE: begin
                            we_q <= 1'b0;
                            rs_q <= RS_FETCH;
                            if (tx_q == tw_m1) begin
                                tx_q <= '0;
                                if (ty_q == th_m1) begin
                                    phase_q <= PH_DONE;
                                end else begin
                                    ty_q <= ty_q + 7'd1;
                                end
                            end else begin
                                tx_q <= tx_q + 7'd1;
                            end
                        end
                        default: rs_q <= RS_FETCH;
                    endcase
                end
                default: phase_q <= PH_DONE;  // held until reset
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (phase_q == PH_RUN && res_valid_i) begin
            if (rs_q == RS_HWAIT) begin
                hres_q[pass_q] <= res_i;
            end
            if (rs_q == RS_VWAIT) begin
                data_q <= res_i;
            end
        end
    end

endmodule

//--- tap_fetch.sv
`timescale 1ns/1ns

module tap_fetch import bicubic_pkg::*; (
    input  logic      CLK,
    input  logic      RST,
    input  coord_t    v0_i,
    input  coord_t    h0_i,
    input  logic      fetch_i,
    input  coord_t    row_sel_i,
    input  coord_t    col_int_i,
    input  frac_t     col_frac_i,
    output logic      rom_en_o,
    output rom_addr_t rom_addr_o,
    input  pixel_t    rom_data_i,
    tap_if.src        horz_tap
);

    logic       rom_en_q;
    logic       data_vld_q;   // rom_data_i valid this cycle
    logic       tap_vld_q;
    logic [1:0] issue_q;      // column offset of the read in flight
    logic [1:0] recv_q;
    coord_t     row_q;
    coord_t     col_q;        // leftmost tap column
    frac_t      frac_q;
    pixel_t     taps_q [4];

    always_ff @(posedge CLK) begin
        if (RST) begin
            rom_en_q   <= 1'b0;
            data_vld_q <= 1'b0;
            tap_vld_q  <= 1'b0;
            issue_q    <= '0;
            recv_q     <= '0;
        end else begin
            data_vld_q <= rom_en_q;
            tap_vld_q  <= data_vld_q && (recv_q == 2'd3);
            if (fetch_i) begin
                rom_en_q <= 1'b1;
                issue_q  <= '0;
            end else if (rom_en_q) begin
                issue_q <= issue_q + 2'd1;
                if (issue_q == 2'd3) begin
                    rom_en_q <= 1'b0;
                end
            end
            if (data_vld_q) begin
                recv_q <= recv_q + 2'd1;  // wraps after the fourth tap
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fetch_i) begin
            row_q  <= v0_i + row_sel_i;
            col_q  <= h0_i + col_int_i - 7'd1;
            frac_q <= col_frac_i;
        end
        if (data_vld_q) begin
            taps_q[0] <= taps_q[1];
            taps_q[1] <= taps_q[2];
            taps_q[2] <= taps_q[3];
            taps_q[3] <= rom_data_i;
        end
    end

    assign rom_en_o   = rom_en_q;
    assign rom_addr_o = rom_addr_t'(row_q * IMG_DIM + col_q + issue_q);

    assign horz_tap.p0    = taps_q[0];
    assign horz_tap.p1    = taps_q[1];
    assign horz_tap.p2    = taps_q[2];
    assign horz_tap.p3    = taps_q[3];
    assign horz_tap.frac  = frac_q;
    assign horz_tap.valid = tap_vld_q;

endmodule

//--- tb.f
bicubic_pkg.sv
bicubic_ifs.sv
phase_divider.sv
phase_table.sv
scan_ctrl.sv
tap_fetch.sv
cubic_engine.sv
bicubic.sv
bicubic_assert.sv
tb_bicubic.sv

//--- tb_bicubic.sv
`timescale 1ns/1ns

module tb_bicubic import bicubic_pkg::*; ();

    logic      CLK;
    logic      RST;
    coord_t    v0;
    coord_t    h0;
    src_size_t sw;
    src_size_t sh;
    tgt_size_t tw;
    tgt_size_t th;
    logic      rom_en;
    rom_addr_t rom_addr;
    pixel_t    rom_data = '0;
    logic      mem_we;
    mem_addr_t mem_addr;
    pixel_t    mem_data;
    logic      done;

    pixel_t    rom_img [IMG_DIM*IMG_DIM];
    int        wr_count [64][64];   // writes seen per target address
    int        wr_total;
    logic      identity;
    logic      rd_pend = 1'b0;
    rom_addr_t rd_addr = '0;
    logic      done_d = 1'b0;
    logic      we_d = 1'b0;
    logic      rst_d = 1'b0;

    bicubic u_bicubic (
        .CLK(CLK), .RST(RST),
        .v0_i(v0), .h0_i(h0), .sw_i(sw), .sh_i(sh), .tw_i(tw), .th_i(th),
        .rom_en_o(rom_en), .rom_addr_o(rom_addr), .rom_data_i(rom_data),
        .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_data_o(mem_data),
        .done_o(done)
    );

    bind bicubic bicubic_assert u_bicubic_assert (
        .CLK(CLK), .RST(RST), .rom_en_o(rom_en_o), .mem_we_o(mem_we_o), .done_o(done_o)
    );

    always #10 CLK = ~CLK;

    // rom answers in the cycle after the read
    always @(negedge CLK) begin
        rd_pend <= rom_en;
        rd_addr <= rom_addr;
    end

    always @(posedge CLK) begin
        #2;
        if (rd_pend) begin
            rom_data = rom_img[rd_addr];
        end
    end

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        stop_with_failure();
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t ns: %s", $time, what);
        stop_with_failure();
    endtask

    // one cubic pass with a q0.8 phase
    function automatic int cubic_ref(input int p0, input int p1, input int p2, input int p3,
                                     input int x);
        int x2;
        int x3;
        int acc;
        x2  = (x * x + 128) >> 8;
        x3  = (x2 * x + 128) >> 8;
        acc = 512 * p1 + x * (p2 - p0) + x2 * (2 * p0 - 5 * p1 + 4 * p2 - p3)
            + x3 * (3 * p1 - 3 * p2 + p3 - p0) + 256;
        acc = acc >>> 9;
        if (acc < 0) return 0;
        if (acc > 255) return 255;
        return acc;
    endfunction

    // source position of target index t on one axis
    function automatic void axis_pos(input int t, input int s, input int n,
                                     output int ip, output int fr);
        int rem;
        ip  = t * (s - 1) / (n - 1);
        rem = t * (s - 1) % (n - 1);
        fr  = rem * 256 / (n - 1);
    endfunction

    function automatic int expected_pixel(input int tx, input int ty);
        int ci;
        int cf;
        int ri;
        int rf;
        int k;
        int base;
        int hv [4];
        axis_pos(tx, sw, tw, ci, cf);
        axis_pos(ty, sh, th, ri, rf);
        for (k = 0; k < 4; k++) begin
            base  = (v0 + ri - 1 + k) * IMG_DIM + h0 + ci - 1;
            hv[k] = cubic_ref(rom_img[base], rom_img[base + 1], rom_img[base + 2],
                              rom_img[base + 3], cf);
        end
        return cubic_ref(hv[0], hv[1], hv[2], hv[3], rf);
    endfunction

    // reads stay inside the window plus its one-pixel and two-pixel border
    task automatic check_rom_read();
        int row;
        int col;
        row = rom_addr / IMG_DIM;
        col = rom_addr % IMG_DIM;
        assert (row >= v0 - 1 && row <= v0 + sh + 1 && col >= h0 - 1 && col <= h0 + sw + 1)
            else report_failure($sformatf("rom read at row %0d col %0d outside the window",
                                          row, col));
    endtask

    task automatic check_write();
        int tx;
        int ty;
        int exp;
        tx = mem_addr[6:0];
        ty = mem_addr[13:7];
        assert (tx < tw && ty < th)
            else report_failure($sformatf("write outside the target at row %0d col %0d", ty, tx));
        assert (wr_count[ty][tx] == 0)
            else report_failure($sformatf("row %0d col %0d written twice", ty, tx));
        wr_count[ty][tx]++;
        wr_total++;
        exp = expected_pixel(tx, ty);
        assert (mem_data == exp)
            else report_mismatch($sformatf("mem_data_o[%0d][%0d]", ty, tx), mem_data, exp);
        if (identity) begin
            exp = rom_img[(v0 + ty) * IMG_DIM + h0 + tx];  // plain copy of the source
            assert (mem_data == exp)
                else report_mismatch($sformatf("mem_data_o[%0d][%0d]", ty, tx), mem_data, exp);
        end
    endtask

    always @(negedge CLK) begin
        if (RST) begin
            if (rst_d) begin
                assert (!rom_en && !mem_we)
                    else report_failure("rom_en_o or mem_we_o high during reset");
            end
        end else begin
            if (rom_en) begin
                check_rom_read();
            end
            if (mem_we) begin
                check_write();
            end
            if (done_d) begin
                assert (done) else report_failure("done_o fell without reset");
            end
            if (done) begin
                assert (!mem_we) else report_failure("write while done_o is high");
            end
            if (done && !done_d) begin
                assert (we_d) else report_failure("done_o did not follow the last write");
                assert (wr_total == tw * th)
                    else report_mismatch("write total at done_o", wr_total, tw * th);
            end
        end
        rst_d  <= RST;
        done_d <= done;
        we_d   <= mem_we;
    end

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!done && n < limit) begin
            @(negedge CLK);
            n++;
        end
        assert (done) else report_failure("timeout waiting for done_o");
    endtask

    task automatic run_case(input int cv0, input int ch0, input int csw, input int csh,
                            input int ctw, input int cth, input logic ident);
        int x;
        int y;
        int n;
        @(posedge CLK);
        #2;
        v0       = coord_t'(cv0);
        h0       = coord_t'(ch0);
        sw       = src_size_t'(csw);
        sh       = src_size_t'(csh);
        tw       = tgt_size_t'(ctw);
        th       = tgt_size_t'(cth);
        identity = ident;
        for (y = 0; y < 64; y++) begin
            for (x = 0; x < 64; x++) begin
                wr_count[y][x] = 0;
            end
        end
        wr_total = 0;
        RST = 1'b1;
        for (n = 0; n < 3; n++) begin
            @(posedge CLK);
        end
        #2;
        RST = 1'b0;
        wait_done(200 * (ctw + cth) + 60 * ctw * cth + 100);
        for (n = 0; n < 20; n++) begin
            @(negedge CLK);   // done_o must hold with no late writes
        end
        assert (wr_total == ctw * cth) else report_mismatch("write total", wr_total, ctw * cth);
        for (y = 0; y < cth; y++) begin
            for (x = 0; x < ctw; x++) begin
                assert (wr_count[y][x] == 1)
                    else report_mismatch($sformatf("write count [%0d][%0d]", y, x),
                                         wr_count[y][x], 1);
            end
        end
    endtask

    initial begin
        int i;
        int rv0;
        int rh0;
        int rsw;
        int rsh;
        int rtw;
        int rth;
        void'($urandom(15));
        CLK      = 1'b0;
        RST      = 1'b1;
        v0       = '0;
        h0       = '0;
        sw       = '0;
        sh       = '0;
        tw       = '0;
        th       = '0;
        identity = 1'b0;
        wr_total = 0;
        for (i = 0; i < IMG_DIM * IMG_DIM; i++) begin
            rom_img[i] = pixel_t'($urandom);
        end

        run_case(18, 81, 17, 15, 22, 28, 1'b0);
        run_case(40, 40, 6, 6, 6, 6, 1'b1);

        rsw = 2 + $urandom % 12;
        rtw = rsw + $urandom % 20;
        rsh = 2 + $urandom % 12;
        rth = rsh + $urandom % 20;
        rh0 = 1 + $urandom % (98 - rsw);
        rv0 = 1 + $urandom % (98 - rsh);
        $display("random geometry v0=%0d h0=%0d sw=%0d sh=%0d tw=%0d th=%0d",
                 rv0, rh0, rsw, rsh, rtw, rth);
        run_case(rv0, rh0, rsw, rsh, rtw, rth, 1'b0);

        $display("Done: no errors");
        $finish;
    end

endmodule
